// File: ControlUnit.sv
`timescale 1ns/1ps

module ControlUnit import PcWordPkg::*; #(
  parameter int NGens = 8,
  parameter int NUnit = 16
) (
  input  logic         clk,
  input  logic         reset,
  // Host word channel
  input  logic         pcValid,
  input  PcWord        pcData,
  output logic         pcReady,
  // Generator programming and time base
  GenProgIf.controller prog
);

  ////////////////////////////////////////////////////////////
  // Word decode

  logic             accept;
  logic             isRegWrite;
  logic             isProgPeriod;
  logic             isProgTag;
  logic [7:0]       genIdx;
  logic [NGens-1:0] genOneHot;

  assign accept = pcValid && pcReady;

  always_comb begin
    isRegWrite   = 1'b0;
    isProgPeriod = 1'b0;
    isProgTag    = 1'b0;
    genIdx       = '0;
    case (pcData.code)
      RegWrite: isRegWrite = 1'b1;
      ProgPeriod: begin
        isProgPeriod = 1'b1;
        genIdx       = pcData.data.progPeriod.gen;
      end
      ProgTag: begin
        isProgTag = 1'b1;
        genIdx    = pcData.data.progTag.gen;
      end
      // Unknown codes are swallowed
      default: ;
    endcase
  end

  // Shifting past the top bit leaves zero, so out-of-range indices load nothing
  assign genOneHot = NGens'(1) << genIdx;

  ////////////////////////////////////////////////////////////
  // Config registers

  logic             enable;
  logic [NUnit-1:0] unitDiv;

  always_ff @(posedge clk) begin
    if (reset) begin
      pcReady <= 1'b0;
      enable  <= 1'b0;
      unitDiv <= '0;
    end else begin
      // Sink never stalls
      pcReady <= 1'b1;
      if (accept && isRegWrite) begin
        case (pcData.data.regWrite.addr)
          RegEnable:  enable  <= pcData.data.regWrite.value[0];
          RegUnitDiv: unitDiv <= pcData.data.regWrite.value[NUnit-1:0];
          default: ;
        endcase
      end
    end
  end

  // Load strobes, one cycle after the word
  always_ff @(posedge clk) begin
    if (reset) begin
      prog.loadPeriod <= '0;
      prog.loadTag    <= '0;
    end else begin
      prog.loadPeriod <= (accept && isProgPeriod) ? genOneHot : '0;
      prog.loadTag    <= (accept && isProgTag) ? genOneHot : '0;
    end
  end

  // Payload rides with the strobes
  always_ff @(posedge clk) begin
    if (accept && isProgPeriod) begin
      prog.period <= pcData.data.progPeriod.period;
    end
    if (accept && isProgTag) begin
      prog.tag <= pcData.data.progTag.tag;
    end
  end

  ////////////////////////////////////////////////////////////
  // Time-unit divider

  logic             running;
  logic             unitWrap;
  logic [NUnit-1:0] divCnt;

  assign running  = enable && (unitDiv != '0);
  // Greater-or-equal catches a divisor shrunk mid-count
  assign unitWrap = running && (divCnt >= unitDiv - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      divCnt             <= '0;
      prog.timeUnitPulse <= 1'b0;
    end else begin
      // Registered, so the first pulse lands divisor cycles after enable
      prog.timeUnitPulse <= unitWrap;
      if (!running || unitWrap) begin
        divCnt <= '0;
      end else begin
        divCnt <= divCnt + 1'b1;
      end
    end
  end

  // A single word never programs both period and tag
  assert property (@(posedge clk) disable iff (reset)
    !((|prog.loadPeriod) && (|prog.loadTag)))
    else $error("period and tag loaded in the same cycle");

endmodule

// File: Interfaces.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Programming bus from the control unit to every generator

interface GenProgIf import SpikeTagPkg::*; #(
  parameter int NGens = 8
) ();

  // One-hot load strobes, one bit per generator
  logic [NGens-1:0] loadPeriod;
  logic [NGens-1:0] loadTag;
  // Shared payload, valid with a strobe
  logic [15:0]      period;
  logic [NTag-1:0]  tag;
  // Time base for all generators
  logic             timeUnitPulse;

  modport controller (
    output loadPeriod, loadTag, period, tag, timeUnitPulse
  );

  modport generator (
    input loadPeriod, loadTag, period, tag, timeUnitPulse
  );

endinterface

////////////////////////////////////////////////////////////
// Request and grant between one generator and the arbiter

interface TagReqIf import SpikeTagPkg::*; ();

  // High while the generator holds a non-zero count
  logic     req;
  TagCtWord word;
  // Generator clears its count on this
  logic     grant;

  modport generator (
    output req, word,
    input  grant
  );

  modport arbiter (
    input  req, word,
    output grant
  );

endinterface

// File: PcWordPkg.sv
package PcWordPkg;

  ////////////////////////////////////////////////////////////
  // Host word layout

  // Opcodes in the top byte of a host word
  typedef enum logic [7:0] {
    RegWrite   = 8'h01,
    ProgPeriod = 8'h02,
    ProgTag    = 8'h03
  } PcOpcode;

  // Register write view
  typedef struct packed {
    logic [7:0]  addr;
    logic [15:0] value;
  } RegWriteData;

  // Generator period view
  typedef struct packed {
    logic [7:0]  gen;
    logic [15:0] period;
  } ProgPeriodData;

  // Generator tag view, upper tag bits reserved
  typedef struct packed {
    logic [7:0]  gen;
    logic [4:0]  rsvd;
    logic [10:0] tag;
  } ProgTagData;

  // Data field, read according to the opcode
  typedef union packed {
    RegWriteData   regWrite;
    ProgPeriodData progPeriod;
    ProgTagData    progTag;
  } PcData;

  // Full 32-bit host word
  typedef struct packed {
    logic [7:0] code;
    PcData      data;
  } PcWord;

  ////////////////////////////////////////////////////////////
  // Register map

  // Bit 0 is the global enable
  localparam logic [7:0] RegEnable  = 8'd0;
  // Clock cycles per time unit
  localparam logic [7:0] RegUnitDiv = 8'd1;

endpackage

// File: SpikeGenCore.sv
`timescale 1ns/1ps

module SpikeGenCore import PcWordPkg::*, SpikeTagPkg::*; #(
  // Generator count
  parameter int NGens   = 8,
  // Period counter width
  parameter int NPeriod = 16,
  // Time-unit divisor width
  parameter int NUnit   = 16
) (
  input  logic     clk,
  input  logic     reset,
  // Host side, 32-bit words
  input  logic     pcValid,
  input  PcWord    pcData,
  output logic     pcReady,
  // Chip side, tag/count words
  output logic     tagValid,
  output TagCtWord tagData,
  input  logic     tagReady
);

  ////////////////////////////////////////////////////////////
  // Internal buses

  // Control unit to the whole bank
  GenProgIf #(.NGens(NGens)) genProg ();

  // One request link per generator
  TagReqIf tagReq [NGens] ();

  ////////////////////////////////////////////////////////////
  // Decode, config and time base

  ControlUnit #(
    .NGens(NGens),
    .NUnit(NUnit)
  ) i_control (
    .clk     (clk),
    .reset   (reset),
    .pcValid (pcValid),
    .pcData  (pcData),
    .pcReady (pcReady),
    .prog    (genProg)
  );

  ////////////////////////////////////////////////////////////
  // Generator bank

  for (genvar g = 0; g < NGens; g++) begin : gGen
    SpikeGenerator #(
      .NGens   (NGens),
      .NPeriod (NPeriod),
      .GenIndex(g)
    ) i_gen (
      .clk   (clk),
      .reset (reset),
      .prog  (genProg),
      .req   (tagReq[g])
    );
  end

  ////////////////////////////////////////////////////////////
  // Drain onto the tag channel

  TagArbiter #(
    .NGens(NGens)
  ) i_arbiter (
    .clk      (clk),
    .reset    (reset),
    .reqs     (tagReq),
    .tagValid (tagValid),
    .tagData  (tagData),
    .tagReady (tagReady)
  );

endmodule

// File: SpikeGenCore_tb.sv
`timescale 1ns/1ps

module SpikeGenCore_tb import SpikeTagPkg::*;;

  // Bank size; the stim file's out-of-range index is 8
  localparam int NGens   = 8;
  localparam int NTags   = 2 ** NTag;
  localparam string StimFile = "spike_stim.txt";

  logic        clk;
  logic        reset;
  logic        pcValid;
  logic [31:0] pcData;
  logic        pcReady;
  logic        tagValid;
  TagCtWord    tagData;
  logic        tagReady;

  // Running per-tag sums and the snapshot at the last compare
  int unsigned sums [NTags];
  int unsigned lastSums [NTags];
  int unsigned expTotals [NTags];
  int          cycleLimit;
  integer      seed = 65179;

  SpikeGenCore #(
    .NGens  (NGens),
    .NPeriod(16),
    .NUnit  (16)
  ) i_dut (
    .clk     (clk),
    .reset   (reset),
    .pcValid (pcValid),
    .pcData  (pcData),
    .pcReady (pcReady),
    .tagValid(tagValid),
    .tagData (tagData),
    .tagReady(tagReady)
  );

  ////////////////////////////////////////////////////////////
  // Clock, watchdog, output monitor

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : watchdog
    int cycleCount;
    cycleCount = 0;
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run timed out after %0d cycles before the stimulus ended", cycleCount);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // Midway between edges everything on the tag channel is settled
  always @(negedge clk) begin
    if (!reset && tagValid && tagReady) begin
      // Generators only request with a pending count
      checkValue("tagData.count non-zero", 32'(tagData.count != '0), 32'd1);
      sums[tagData.tag] += tagData.count;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stopOnBadStim(input string what);
    $display("Stimulus problem: %s", what);
    $display("test failed");
    $fatal(1, "bad stimulus");
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // Valid/ready transfer of one host word
  task automatic sendWord(input logic [7:0] code, input logic [23:0] data);
    pcData  = {code, data};
    pcValid = 1'b1;
    while (!pcReady) tick();
    tick();
    pcValid = 1'b0;
  endtask

  // Mode 0 holds tagReady low, 1 high, 2 random
  task automatic runCycles(input int n, input int mode);
    int rnd;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      case (mode)
        0:       tagReady = 1'b0;
        1:       tagReady = 1'b1;
        default: tagReady = rnd[0];
      endcase
      checkValue("pcReady", 32'(pcReady), 32'd1);
      tick();
    end
  endtask

  // Sums since the previous compare against the E lines
  task automatic checkTotals();
    for (int t = 0; t < NTags; t++) begin
      checkValue($sformatf("tagData.count total for tag 0x%03h", t),
                 sums[t] - lastSums[t], expTotals[t]);
      lastSums[t]  = sums[t];
      expTotals[t] = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stim file passes

  // Limit is all run cycles plus 200 per compare
  task automatic computeLimit();
    int fd, n, cycles, mode, tests;
    logic [63:0]       op;
    logic [8*160-1:0]  rest;
    fd = $fopen(StimFile, "r");
    if (fd == 0) stopOnBadStim("cannot open spike_stim.txt");
    cycles = 0;
    tests  = 0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "R") begin
        if ($fscanf(fd, "%d %d", n, mode) != 2) begin
          stopOnBadStim("malformed run line in spike_stim.txt");
        end
        cycles += n;
      end else if (op == "C") begin
        tests++;
      end else begin
        n = $fgets(rest, fd);
      end
    end
    $fclose(fd);
    cycleLimit = cycles + 200 * tests;
  endtask

  task automatic runStim();
    int fd, n, a, b;
    logic [63:0]       op;
    logic [7:0]        code;
    logic [23:0]       data;
    logic [NTag-1:0]   tag;
    logic [8*160-1:0]  rest;
    fd = $fopen(StimFile, "r");
    if (fd == 0) stopOnBadStim("cannot open spike_stim.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      case (op)
        "W": begin
          n = $fscanf(fd, "%h %h", code, data);
          sendWord(code, data);
        end
        "R": begin
          n = $fscanf(fd, "%d %d", a, b);
          runCycles(a, b);
        end
        "E": begin
          n = $fscanf(fd, "%h %d", tag, b);
          expTotals[tag] += b;
        end
        "C": checkTotals();
        "#": n = $fgets(rest, fd);
        default: stopOnBadStim("unknown command in spike_stim.txt");
      endcase
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : mainFlow
    reset      = 1'b1;
    pcValid    = 1'b0;
    pcData     = '0;
    tagReady   = 1'b0;
    cycleLimit = 0;
    computeLimit();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // Sink comes up one cycle after reset
    while (!pcReady) tick();
    runStim();
    $display("test passed");
    $finish;
  end

endmodule

// File: SpikeGenerator.sv
`timescale 1ns/1ps

module SpikeGenerator import SpikeTagPkg::*; #(
  parameter int NGens    = 8,
  parameter int NPeriod  = 16,
  parameter int GenIndex = 0
) (
  input logic         clk,
  input logic         reset,
  GenProgIf.generator prog,
  TagReqIf.generator  req
);

  // Index has to hit a bit of the load vectors
  if (GenIndex >= NGens) begin : gBadIndex
    $error("generator index %0d out of range for %0d generators", GenIndex, NGens);
  end

  logic [NPeriod-1:0] period;
  logic [NPeriod-1:0] phase;
  logic [NPeriod-1:0] phaseNext;
  logic [NTag-1:0]    tag;
  logic [NCount-1:0]  count;
  logic               loadPeriod;
  logic               loadTag;
  logic               spike;

  assign loadPeriod = prog.loadPeriod[GenIndex];
  assign loadTag    = prog.loadTag[GenIndex];

  ////////////////////////////////////////////////////////////
  // Period counter

  assign phaseNext = phase + 1'b1;
  // Period zero never spikes
  assign spike = prog.timeUnitPulse && (period != '0) && (phaseNext == period);

  always_ff @(posedge clk) begin
    if (reset) begin
      period <= '0;
      phase  <= '0;
    end else if (loadPeriod) begin
      // New period restarts the phase
      period <= prog.period[NPeriod-1:0];
      phase  <= '0;
    end else if (prog.timeUnitPulse && (period != '0)) begin
      phase <= spike ? '0 : phaseNext;
    end
  end

  always_ff @(posedge clk) begin
    if (loadTag) begin
      tag <= prog.tag;
    end
  end

  ////////////////////////////////////////////////////////////
  // Spike count

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (req.grant) begin
      // Drained this cycle; a coincident spike starts the next batch
      count <= spike ? NCount'(1) : '0;
    end else if (spike && (count != MaxCount)) begin
      count <= count + 1'b1;
    end
  end

  // Request while anything is pending
  assign req.req        = (count != '0);
  assign req.word.tag   = tag;
  assign req.word.count = count;

  // Saturated count holds until the arbiter takes it
  assert property (@(posedge clk) disable iff (reset)
    (count == MaxCount) && !req.grant |=> (count != '0))
    else $error("generator %0d count wrapped", GenIndex);

endmodule

// File: SpikeTagPkg.sv
package SpikeTagPkg;

  ////////////////////////////////////////////////////////////
  // Chip-side tag words

  // Tag width
  localparam int NTag = 11;

  // Spike count width
  localparam int NCount = 9;

  // Counts saturate here
  localparam logic [NCount-1:0] MaxCount = '1;

  // One tag plus its accumulated count, 20 bits
  typedef struct packed {
    logic [NTag-1:0]   tag;
    logic [NCount-1:0] count;
  } TagCtWord;

endpackage

// File: TagArbiter.sv
`timescale 1ns/1ps

module TagArbiter import SpikeTagPkg::*; #(
  parameter int NGens = 8
) (
  input  logic     clk,
  input  logic     reset,
  // Requests from the generator bank
  TagReqIf.arbiter reqs [NGens],
  // Output tag channel
  output logic     tagValid,
  output TagCtWord tagData,
  input  logic     tagReady
);

  // Pointer width, kept at least one bit
  localparam int NIdx = (NGens > 1) ? $clog2(NGens) : 1;

  logic [NGens-1:0] reqVec;
  logic [NGens-1:0] grantVec;
  TagCtWord         words [NGens];
  logic [NIdx-1:0]  ptr;
  logic [NIdx-1:0]  pick;
  logic             found;
  logic             canLoad;

  ////////////////////////////////////////////////////////////
  // Flatten the request array

  for (genvar g = 0; g < NGens; g++) begin : gPort
    assign reqVec[g]     = reqs[g].req;
    assign words[g]      = reqs[g].word;
    assign reqs[g].grant = grantVec[g];
  end

  ////////////////////////////////////////////////////////////
  // Round-robin pick

  // Output register free now or emptied this cycle
  assign canLoad = !tagValid || tagReady;

  // Scan from the pointer, first requester wins
  always_comb begin
    int cand;
    found = 1'b0;
    pick  = '0;
    for (int k = 0; k < NGens; k++) begin
      cand = (int'(ptr) + k) % NGens;
      if (!found && reqVec[cand]) begin
        found = 1'b1;
        pick  = NIdx'(cand);
      end
    end
  end

  assign grantVec = (canLoad && found) ? (NGens'(1) << pick) : '0;

  ////////////////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk) begin
    if (reset) begin
      tagValid <= 1'b0;
      ptr      <= '0;
    end else if (canLoad) begin
      tagValid <= found;
      // Next search starts just past the winner
      if (found) begin
        ptr <= (pick == NIdx'(NGens - 1)) ? '0 : pick + 1'b1;
      end
    end
  end

  // Word captured on the same edge the generator clears
  always_ff @(posedge clk) begin
    if (canLoad && found) begin
      tagData <= words[pick];
    end
  end

  // At most one grant, and only to a requester
  assert property (@(posedge clk) disable iff (reset)
    $onehot0(grantVec) && ((grantVec & ~reqVec) == '0))
    else $error("bad grant vector %b for requests %b", grantVec, reqVec);

  // Held word stays put under backpressure
  assert property (@(posedge clk) disable iff (reset)
    tagValid && !tagReady |=> tagValid && $stable(tagData))
    else $error("tagData changed while stalled");

endmodule

// File: all.f
PcWordPkg.sv
SpikeTagPkg.sv
Interfaces.sv
ControlUnit.sv
SpikeGenerator.sv
TagArbiter.sv
SpikeGenCore.sv
SpikeGenCore_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module SpikeGenCore_tb -f all.f -o simv \
  && ./obj_dir/simv \
  || { echo "simulation did not complete cleanly"; exit 1; }

// File: spike_stim.txt
# W code data = host word in hex | R cycles mode = run, tagReady 0 low, 1 high, 2 random
# E tag total = expected sum for a hex tag | C = compare sums since the last C, then clear
R 50 1
C
W 02 000003
W 03 00002A
W 01 010004
W 01 000001
R 120 1
W 01 000000
R 40 1
E 02A 10
C
W 02 010002
W 03 010101
W 02 020005
W 03 020202
W 02 030007
W 03 030303
W 02 040001
W 03 0407FF
W 01 000001
R 200 2
W 01 000000
R 60 1
E 02A 16
E 101 25
E 202 10
E 303 7
E 7FF 50
C
W 02 000000
W 02 020000
W 02 030000
W 02 040000
W 02 010001
W 01 010002
W 01 000001
R 9 0
W 01 000000
W 02 010000
W 02 020007
W 02 040001
W 01 000001
R 1200 0
W 01 000000
R 60 1
E 101 5
E 202 85
E 7FF 511
C
W 02 020003
W 02 040000
W 55 010001
W 02 080001
W 01 000001
R 60 1
W 01 000000
R 40 1
E 202 10
C
W 02 020003
W 02 010002
W 01 000001
R 40 1
W 02 010000
R 80 1
W 01 000000
R 40 1
E 101 10
E 202 20
C
